// File: lcd_pkg.sv
// lcd panel package: widths, timing counts, register offsets, init table, bus and pin types
package lcd_pkg;

    localparam int LCD_DW = 16;        // panel data bus
    localparam int WB_DW  = 32;
    localparam int WB_AW  = 2;         // word address bits

    // register map, word offsets
    localparam logic [WB_AW-1:0] REG_XFER   = 2'd0;
    localparam logic [WB_AW-1:0] REG_PIXELS = 2'd1;
    localparam logic [WB_AW-1:0] REG_READ   = 2'd2;
    localparam logic [WB_AW-1:0] REG_STATUS = 2'd3;

    localparam int RST_CYCLES    = 32; // panel reset low time
    localparam int WR_LOW_CYCLES = 2;
    localparam int RD_LOW_CYCLES = 4;  // data sampled on the last one
    localparam int INIT_LEN      = 8;

    localparam int RST_CNT_W  = $clog2(RST_CYCLES + 1);
    localparam int LOW_CNT_W  = $clog2(RD_LOW_CYCLES + 1);
    localparam int INIT_IDX_W = $clog2(INIT_LEN);

    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [WB_AW-1:0] adr;
        logic [WB_DW-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic             ack;
        logic [WB_DW-1:0] dat;
    } wb_rsp_t;

    // one panel cycle
    typedef struct packed {
        logic              rs;   // 0 command, 1 data
        logic              rd;   // 1 for a read cycle
        logic [LCD_DW-1:0] data;
    } lcd_op_t;

    typedef struct packed {
        logic              rs;
        logic [LCD_DW-1:0] value;
    } init_entry_t;

    typedef struct packed {
        logic [14:0]       rsvd;
        logic              rs;
        logic [LCD_DW-1:0] value;
    } xfer_word_t;

    typedef struct packed {
        logic [LCD_DW-1:0] pix_first;  // sent first
        logic [LCD_DW-1:0] pix_second;
    } pixels_word_t;

    // bus write word, REG_XFER or REG_PIXELS view
    typedef union packed {
        xfer_word_t   xfer;
        pixels_word_t pixels;
    } lcd_word_u;

    typedef struct packed {
        logic              rst_n;
        logic              cs_n;
        logic              rs;
        logic              wr_n;
        logic              rd_n;
        logic              bl;
        logic [LCD_DW-1:0] data_out;
        logic              data_oe;
    } lcd_pins_t;

    // power-up sequence, rs then value
    localparam init_entry_t [0:INIT_LEN-1] INIT_TABLE = {
        init_entry_t'{1'b0, 16'h0001},  // software reset
        init_entry_t'{1'b0, 16'h0011},  // sleep out
        init_entry_t'{1'b0, 16'h003A},  // pixel format
        init_entry_t'{1'b1, 16'h0055},  // 16 bpp
        init_entry_t'{1'b0, 16'h0036},  // memory access control
        init_entry_t'{1'b1, 16'h0048},
        init_entry_t'{1'b0, 16'h0013},  // normal mode
        init_entry_t'{1'b0, 16'h0029}   // display on
    };

endpackage

// File: lcd_bus_slave.sv
// wishbone classic slave: register decode, panel request hand-off, read data return
`timescale 1ns/1ps
module lcd_bus_slave (
    input  logic                       pclk,
    input  logic                       rst_n,
    input  lcd_pkg::wb_req_t           wb_i,
    output lcd_pkg::wb_rsp_t           wb_o,
    input  logic                       init_finished_i,
    output logic                       req_valid_o,
    output lcd_pkg::lcd_op_t           req_op_o,
    output logic                       req_pair_o,
    output logic [lcd_pkg::LCD_DW-1:0] req_pix2_o,
    input  logic                       req_accept_i,
    input  logic [lcd_pkg::LCD_DW-1:0] rdata_i
);

    lcd_pkg::lcd_word_u        word;
    lcd_pkg::lcd_op_t          next_op;
    logic                      next_pair;
    logic                      is_req;
    logic                      status_rd;
    logic                      access;
    logic                      ack_q;
    logic [lcd_pkg::WB_DW-1:0] dat_q;

    assign word      = wb_i.dat;
    assign access    = wb_i.cyc && wb_i.stb && !ack_q && !req_valid_o;
    assign status_rd = !wb_i.we && (wb_i.adr == lcd_pkg::REG_STATUS);

    // which accesses turn into panel requests
    always_comb begin
        is_req    = 1'b0;
        next_op   = '0;
        next_pair = 1'b0;
        if (wb_i.we) begin
            case (wb_i.adr)
                lcd_pkg::REG_XFER: begin
                    is_req       = 1'b1;
                    next_op.rs   = word.xfer.rs;
                    next_op.data = word.xfer.value;
                end
                lcd_pkg::REG_PIXELS: begin
                    is_req       = 1'b1;
                    next_op.rs   = 1'b1;  // pixels are always data
                    next_op.data = word.pixels.pix_first;
                    next_pair    = 1'b1;
                end
                default: ;
            endcase
        end else if (wb_i.adr == lcd_pkg::REG_READ) begin
            is_req     = 1'b1;
            next_op.rs = 1'b1;
            next_op.rd = 1'b1;
        end
    end

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            req_valid_o <= 1'b0;
            ack_q       <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            if (req_valid_o && req_accept_i) begin
                req_valid_o <= 1'b0;
                ack_q       <= 1'b1;
            end else if (access) begin
                if (is_req)
                    req_valid_o <= 1'b1;
                else
                    ack_q <= 1'b1;  // status or no-effect access
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (access) begin
            req_op_o   <= next_op;
            req_pair_o <= next_pair;
            req_pix2_o <= word.pixels.pix_second;
            dat_q      <= status_rd ? {{(lcd_pkg::WB_DW-1){1'b0}}, init_finished_i} : '0;
        end else if (req_valid_o && req_accept_i) begin
            dat_q <= req_op_o.rd ? {{(lcd_pkg::WB_DW-lcd_pkg::LCD_DW){1'b0}}, rdata_i} : '0;
        end
    end

    assign wb_o.ack = ack_q;
    assign wb_o.dat = dat_q;

endmodule

// File: lcd_xfer_seq.sv
// transfer sequencer: init versus bus arbitration, pixel pair split into two panel ops
`timescale 1ns/1ps
module lcd_xfer_seq (
    input  logic                       pclk,
    input  logic                       rst_n,
    input  logic                       req_valid_i,
    input  lcd_pkg::lcd_op_t           req_op_i,
    input  logic                       req_pair_i,
    input  logic [lcd_pkg::LCD_DW-1:0] req_pix2_i,
    output logic                       req_accept_o,
    output logic [lcd_pkg::LCD_DW-1:0] rdata_o,
    input  logic                       init_valid_i,
    input  lcd_pkg::init_entry_t       init_entry_i,
    input  logic                       init_finished_i,
    output logic                       init_done_o,
    output logic                       op_valid_o,
    output lcd_pkg::lcd_op_t           op_o,
    input  logic                       op_done_i,
    input  logic [lcd_pkg::LCD_DW-1:0] rdata_i
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_INIT,   // init entry on the panel
        S_REQ     // bus request on the panel
    } seq_state_e;

    seq_state_e                 state;
    lcd_pkg::lcd_op_t           op_q;
    logic                       pair_q;  // second pixel still to go
    logic [lcd_pkg::LCD_DW-1:0] pix2_q;

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            state  <= S_IDLE;
            pair_q <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (!init_finished_i && init_valid_i) begin
                        state <= S_INIT;
                    end else if (init_finished_i && req_valid_i) begin
                        state  <= S_REQ;
                        pair_q <= req_pair_i;
                    end
                end
                S_INIT: if (op_done_i) state <= S_IDLE;
                S_REQ: begin
                    if (op_done_i) begin
                        if (pair_q)
                            pair_q <= 1'b0;  // back to back, stay busy
                        else
                            state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // op payload, loaded from whichever source wins
    always_ff @(posedge pclk) begin
        if (state == S_IDLE) begin
            if (!init_finished_i)
                op_q <= '{rs: init_entry_i.rs, rd: 1'b0, data: init_entry_i.value};
            else
                op_q <= req_op_i;
            pix2_q <= req_pix2_i;
        end else if (state == S_REQ && op_done_i && pair_q) begin
            op_q.data <= pix2_q;
        end
    end

    assign op_valid_o   = (state != S_IDLE);
    assign op_o         = op_q;
    assign init_done_o  = (state == S_INIT) && op_done_i;
    assign req_accept_o = (state == S_REQ) && op_done_i && !pair_q;
    assign rdata_o      = rdata_i;  // held by the pin engine after a read

endmodule

// File: lcd_init_seq.sv
// init player: panel reset pulse, then power-up table playback
`timescale 1ns/1ps
module lcd_init_seq (
    input  logic                 pclk,
    input  logic                 rst_n,
    output logic                 init_valid_o,
    output lcd_pkg::init_entry_t init_entry_o,
    input  logic                 init_done_i,
    output logic                 init_finished_o,
    output logic                 panel_rst_n_o
);

    typedef enum logic [1:0] {
        S_RST,
        S_PLAY,
        S_DONE
    } init_state_e;

    init_state_e                    state;
    logic [lcd_pkg::RST_CNT_W-1:0]  rst_cnt;
    logic [lcd_pkg::INIT_IDX_W-1:0] idx;

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            state         <= S_RST;
            rst_cnt       <= '0;
            idx           <= '0;
            panel_rst_n_o <= 1'b0;
        end else begin
            case (state)
                S_RST: begin
                    rst_cnt <= rst_cnt + 1'b1;
                    if (rst_cnt == lcd_pkg::RST_CNT_W'(lcd_pkg::RST_CYCLES - 1))
                        panel_rst_n_o <= 1'b1;
                    // one spare clock after the pulse before the first entry
                    if (rst_cnt == lcd_pkg::RST_CNT_W'(lcd_pkg::RST_CYCLES))
                        state <= S_PLAY;
                end
                S_PLAY: begin
                    if (init_done_i) begin
                        if (idx == lcd_pkg::INIT_IDX_W'(lcd_pkg::INIT_LEN - 1))
                            state <= S_DONE;
                        else
                            idx <= idx + 1'b1;
                    end
                end
                default: ;  // done, stays here until reset
            endcase
        end
    end

    assign init_valid_o    = (state == S_PLAY);
    assign init_entry_o    = lcd_pkg::INIT_TABLE[idx];
    assign init_finished_o = (state == S_DONE);

endmodule

// File: lcd_pin_timing.sv
// 8080 pin timing engine: write and read strobes, read capture, backlight
`timescale 1ns/1ps
module lcd_pin_timing (
    input  logic                       pclk,
    input  logic                       rst_n,
    input  logic                       panel_rst_n_i,
    input  logic                       init_finished_i,
    input  logic                       op_valid_i,
    input  lcd_pkg::lcd_op_t           op_i,
    output logic                       op_done_o,
    output logic [lcd_pkg::LCD_DW-1:0] rdata_o,
    output lcd_pkg::lcd_pins_t         pins_o,
    input  logic [lcd_pkg::LCD_DW-1:0] data_in_i
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_SETUP,    // cs low, rs and data settle
        S_LOW,      // wr or rd strobe low
        S_RELEASE   // strobe back high, op done
    } pin_state_e;

    pin_state_e                    state;
    lcd_pkg::lcd_op_t              op_q;
    logic [lcd_pkg::LOW_CNT_W-1:0] low_cnt;
    logic [lcd_pkg::LOW_CNT_W-1:0] low_last;
    logic                          bl_q;

    assign low_last = op_q.rd ? lcd_pkg::LOW_CNT_W'(lcd_pkg::RD_LOW_CYCLES - 1)
                              : lcd_pkg::LOW_CNT_W'(lcd_pkg::WR_LOW_CYCLES - 1);

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            low_cnt <= '0;
            bl_q    <= 1'b0;
        end else begin
            bl_q <= init_finished_i;  // backlight on once the panel is set up
            case (state)
                S_IDLE:  if (op_valid_i) state <= S_SETUP;
                S_SETUP: begin
                    state   <= S_LOW;
                    low_cnt <= '0;
                end
                S_LOW: begin
                    if (low_cnt == low_last)
                        state <= S_RELEASE;
                    else
                        low_cnt <= low_cnt + 1'b1;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge pclk) begin
        if (state == S_IDLE && op_valid_i)
            op_q <= op_i;
        if (state == S_LOW && low_cnt == low_last && op_q.rd)
            rdata_o <= data_in_i;  // last read-low cycle
    end

    assign op_done_o = (state == S_RELEASE);

    always_comb begin
        pins_o.rst_n    = panel_rst_n_i;
        pins_o.cs_n     = (state == S_IDLE);
        pins_o.rs       = op_q.rs;
        pins_o.wr_n     = !((state == S_LOW) && !op_q.rd);
        pins_o.rd_n     = !((state == S_LOW) && op_q.rd);
        pins_o.bl       = bl_q;
        pins_o.data_out = op_q.data;
        pins_o.data_oe  = (state != S_IDLE) && !op_q.rd;  // drive through release for hold
    end

endmodule

// File: lcd_top.sv
// lcd controller top: bus slave, transfer sequencer, init player, pin timing
`timescale 1ns/1ps
module lcd_top (
    input  logic                       pclk,
    input  logic                       rst_n,
    input  lcd_pkg::wb_req_t           wb_i,
    output lcd_pkg::wb_rsp_t           wb_o,
    output lcd_pkg::lcd_pins_t         pins_o,
    input  logic [lcd_pkg::LCD_DW-1:0] data_in_i
);

    // bus slave <-> sequencer
    logic                       req_valid;
    lcd_pkg::lcd_op_t           req_op;
    logic                       req_pair;
    logic [lcd_pkg::LCD_DW-1:0] req_pix2;
    logic                       req_accept;
    logic [lcd_pkg::LCD_DW-1:0] req_rdata;

    // init player <-> sequencer
    logic                       init_valid;
    lcd_pkg::init_entry_t       init_entry;
    logic                       init_done;
    logic                       init_finished;
    logic                       panel_rst_n;

    // sequencer <-> pin timing
    logic                       op_valid;
    lcd_pkg::lcd_op_t           op;
    logic                       op_done;
    logic [lcd_pkg::LCD_DW-1:0] op_rdata;

    lcd_bus_slave u_bus_slave (
        .pclk            (pclk),
        .rst_n           (rst_n),
        .wb_i            (wb_i),
        .wb_o            (wb_o),
        .init_finished_i (init_finished),
        .req_valid_o     (req_valid),
        .req_op_o        (req_op),
        .req_pair_o      (req_pair),
        .req_pix2_o      (req_pix2),
        .req_accept_i    (req_accept),
        .rdata_i         (req_rdata)
    );

    lcd_xfer_seq u_xfer_seq (
        .pclk            (pclk),
        .rst_n           (rst_n),
        .req_valid_i     (req_valid),
        .req_op_i        (req_op),
        .req_pair_i      (req_pair),
        .req_pix2_i      (req_pix2),
        .req_accept_o    (req_accept),
        .rdata_o         (req_rdata),
        .init_valid_i    (init_valid),
        .init_entry_i    (init_entry),
        .init_finished_i (init_finished),
        .init_done_o     (init_done),
        .op_valid_o      (op_valid),
        .op_o            (op),
        .op_done_i       (op_done),
        .rdata_i         (op_rdata)
    );

    lcd_init_seq u_init_seq (
        .pclk            (pclk),
        .rst_n           (rst_n),
        .init_valid_o    (init_valid),
        .init_entry_o    (init_entry),
        .init_done_i     (init_done),
        .init_finished_o (init_finished),
        .panel_rst_n_o   (panel_rst_n)
    );

    lcd_pin_timing u_pin_timing (
        .pclk            (pclk),
        .rst_n           (rst_n),
        .panel_rst_n_i   (panel_rst_n),
        .init_finished_i (init_finished),
        .op_valid_i      (op_valid),
        .op_i            (op),
        .op_done_o       (op_done),
        .rdata_o         (op_rdata),
        .pins_o          (pins_o),
        .data_in_i       (data_in_i)
    );

endmodule

// File: lcd_top_properties.sv
// protocol assertions on the 8080 pins and the wishbone port of lcd_top, attached by bind
`timescale 1ns/1ps
module lcd_top_properties (
    input logic               pclk,
    input logic               rst_n,
    input lcd_pkg::wb_req_t   wb_i,
    input lcd_pkg::wb_rsp_t   wb_rsp_i,
    input lcd_pkg::lcd_pins_t pins_i
);

    // a strobe only ever moves inside a chip select
    strobe_needs_cs: assert property (@(posedge pclk) disable iff (!rst_n)
        (!pins_i.wr_n || !pins_i.rd_n) |-> !pins_i.cs_n)
        else $error("wr_n or rd_n low while cs_n is high");

    one_strobe: assert property (@(posedge pclk) disable iff (!rst_n)
        !(!pins_i.wr_n && !pins_i.rd_n))
        else $error("wr_n and rd_n low together");

    no_drive_on_read: assert property (@(posedge pclk) disable iff (!rst_n)
        pins_i.data_oe |-> pins_i.rd_n)
        else $error("data_oe high during a read strobe");

    ack_in_cycle: assert property (@(posedge pclk) disable iff (!rst_n)
        wb_rsp_i.ack |-> (wb_i.cyc && wb_i.stb))
        else $error("ack without cyc and stb");

endmodule

bind lcd_top lcd_top_properties u_properties (
    .pclk     (pclk),
    .rst_n    (rst_n),
    .wb_i     (wb_i),
    .wb_rsp_i (wb_o),
    .pins_i   (pins_o)
);

// File: tb_lcd_top.sv
// lcd_top testbench with clock, reset, wishbone tasks, panel model, vector reader and compare tasks
`timescale 1ns/1ps
module tb_lcd_top;

    localparam int ACK_TIMEOUT = 400;  // cycles
    localparam int RST_TIMEOUT = 100;

    typedef struct packed {
        logic [7:0]                 kind;   // "W" or "R"
        logic [lcd_pkg::WB_AW-1:0]  adr;
        logic [lcd_pkg::WB_DW-1:0]  dat;    // write data or expected read data
        logic [1:0]                 nops;
        lcd_pkg::lcd_op_t           op0;
        lcd_pkg::lcd_op_t           op1;
        logic [lcd_pkg::LCD_DW-1:0] panel;  // panel answer on a read
    } access_t;

    logic                       pclk;
    logic                       rst_n;
    lcd_pkg::wb_req_t           wb_req;
    lcd_pkg::wb_rsp_t           wb_rsp;
    lcd_pkg::lcd_pins_t         pins;
    logic [lcd_pkg::LCD_DW-1:0] data_in;
    logic [lcd_pkg::LCD_DW-1:0] read_value;
    lcd_pkg::lcd_op_t           seen_ops[$];  // filled by the panel model
    lcd_pkg::lcd_op_t           init_ops[$];
    access_t                    accesses[$];
    integer                     seed;

    lcd_top dut (
        .pclk      (pclk),
        .rst_n     (rst_n),
        .wb_i      (wb_req),
        .wb_o      (wb_rsp),
        .pins_o    (pins),
        .data_in_i (data_in)
    );

    initial begin
        pclk = 1'b0;
        forever #2 pclk = ~pclk;
    end

    function automatic lcd_pkg::lcd_op_t write_op(input logic rs, input logic [15:0] data);
        write_op = '{rs: rs, rd: 1'b0, data: data};
    endfunction

    // panel model
    assign data_in = (pins.rd_n == 1'b0) ? read_value : '0;

    always @(posedge pins.wr_n) begin
        if (rst_n) begin
            check_pin("data_oe at wr_n rise", 1'b1, pins.data_oe);  // data must be driven here
            seen_ops.push_back(write_op(pins.rs, pins.data_out));  // latched on the rising edge
        end
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "%s", what);
    endtask

    task automatic check_op(input string name, input lcd_pkg::lcd_op_t exp,
                            input lcd_pkg::lcd_op_t act);
        if (act !== exp)
            stop_on_error($sformatf("mismatch %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_word(input string name, input logic [lcd_pkg::WB_DW-1:0] exp,
                              input logic [lcd_pkg::WB_DW-1:0] act);
        if (act !== exp)
            stop_on_error($sformatf("mismatch %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_pin(input string name, input logic exp, input logic act);
        if (act !== exp)
            stop_on_error($sformatf("mismatch %s expected %b actual %b", name, exp, act));
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge pclk);
            #1;
        end
    endtask

    task automatic load_vectors();
        int                         fd;
        int                         n;
        logic [7:0]                 kind;
        logic [8*80-1:0]            rest;
        access_t                    a;
        logic [lcd_pkg::WB_AW-1:0]  adr;
        logic [lcd_pkg::WB_DW-1:0]  dat;
        logic [1:0]                 nops;
        logic                       rs0;
        logic                       rs1;
        logic [lcd_pkg::LCD_DW-1:0] d0;
        logic [lcd_pkg::LCD_DW-1:0] d1;
        fd = $fopen("lcd_vectors.txt", "r");
        if (fd == 0)
            stop_on_error("cannot open lcd_vectors.txt");
        while (!$feof(fd)) begin
            kind = 8'h00;
            a    = '0;
            n    = $fscanf(fd, "%s", kind);
            if (kind == "#") begin
                n = $fgets(rest, fd);  // rest of a comment line
            end else if (kind == "I") begin
                n = $fscanf(fd, "%h %h", rs0, d0);
                if (n != 2)
                    stop_on_error("short init line in the vector file");
                init_ops.push_back(write_op(rs0, d0));
            end else if (kind == "W") begin
                n = $fscanf(fd, "%h %h %h %h %h %h %h", adr, dat, nops, rs0, d0, rs1, d1);
                if (n != 7)
                    stop_on_error("short write line in the vector file");
                a.kind = kind;
                a.adr  = adr;
                a.dat  = dat;
                a.nops = nops;
                a.op0  = write_op(rs0, d0);
                a.op1  = write_op(rs1, d1);
                accesses.push_back(a);
            end else if (kind == "R") begin
                n = $fscanf(fd, "%h %h %h", adr, d0, dat);
                if (n != 3)
                    stop_on_error("short read line in the vector file");
                a.kind  = kind;
                a.adr   = adr;
                a.panel = d0;
                a.dat   = dat;
                accesses.push_back(a);
            end else if (kind != 8'h00) begin
                stop_on_error("unknown line kind in the vector file");
            end
        end
        $fclose(fd);
    endtask

    // wishbone classic cycle with stb dropped the cycle after ack
    task automatic bus_access(input logic we, input logic [lcd_pkg::WB_AW-1:0] adr,
                              input logic [lcd_pkg::WB_DW-1:0] dat,
                              output logic [lcd_pkg::WB_DW-1:0] rdat);
        int cycles;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
        cycles     = 0;
        while (wb_rsp.ack !== 1'b1 && cycles < ACK_TIMEOUT) begin
            @(posedge pclk);
            #1;
            cycles++;
        end
        if (wb_rsp.ack !== 1'b1)
            stop_on_error($sformatf("no ack within %0d cycles at address %0d", ACK_TIMEOUT, adr));
        rdat = wb_rsp.dat;
        @(posedge pclk);
        #1;
        wb_req = '0;
    endtask

    task automatic wait_panel_reset();
        int cycles;
        cycles = 0;
        while (pins.rst_n !== 1'b1 && cycles < RST_TIMEOUT) begin
            @(posedge pclk);
            #1;
            cycles++;
        end
        if (pins.rst_n !== 1'b1)
            stop_on_error("panel reset never went high");
    endtask

    task automatic check_recorded_writes(input string name, input access_t a);
        check_word({name, " op count"}, 32'(a.nops), 32'(seen_ops.size()));
        if (a.nops > 2'd0)
            check_op({name, " first op"}, a.op0, seen_ops.pop_front());
        if (a.nops > 2'd1)
            check_op({name, " second op"}, a.op1, seen_ops.pop_front());
    endtask

    task automatic run_access(input int idx, input access_t a);
        logic [lcd_pkg::WB_DW-1:0] rdat;
        string                     name;
        name = $sformatf("vector %0d adr %0d", idx, a.adr);
        if (a.kind == "W") begin
            bus_access(1'b1, a.adr, a.dat, rdat);
            check_recorded_writes(name, a);
        end else begin
            read_value = a.panel;
            bus_access(1'b0, a.adr, '0, rdat);
            check_word(name, a.dat, rdat);
            check_word({name, " writes seen"}, 32'd0, 32'(seen_ops.size()));
        end
    endtask

    initial begin
        logic [lcd_pkg::WB_DW-1:0] rdat;
        int                        gap;
        seed       = 75404;
        rst_n      = 1'b0;
        wb_req     = '0;
        read_value = '0;
        load_vectors();
        if (init_ops.size() != lcd_pkg::INIT_LEN)
            stop_on_error("vector file does not hold the whole init table");
        if (accesses.size() == 0 || accesses[0].kind != "W")
            stop_on_error("first access in the vector file is not a write");
        repeat (16) @(posedge pclk);
        #1 rst_n = 1'b1;
        check_pin("panel reset after rst_n", 1'b0, pins.rst_n);
        check_pin("cs_n after rst_n", 1'b1, pins.cs_n);
        check_pin("wr_n after rst_n", 1'b1, pins.wr_n);
        check_pin("rd_n after rst_n", 1'b1, pins.rd_n);
        check_pin("data_oe after rst_n", 1'b0, pins.data_oe);
        check_pin("backlight after rst_n", 1'b0, pins.bl);
        wait_panel_reset();

        // first write goes out while the init table is still playing
        bus_access(1'b1, accesses[0].adr, accesses[0].dat, rdat);
        check_word("ops at first write ack", 32'(lcd_pkg::INIT_LEN + accesses[0].nops),
                   32'(seen_ops.size()));
        for (int i = 0; i < lcd_pkg::INIT_LEN; i++)
            check_op($sformatf("init entry %0d", i), init_ops[i], seen_ops.pop_front());
        check_recorded_writes("write during init", accesses[0]);
        check_pin("backlight after init", 1'b1, pins.bl);

        for (int i = 1; i < accesses.size(); i++) begin
            gap = $random(seed) & 3;  // 0 to 3 idle cycles
            idle_cycles(gap);
            run_access(i, accesses[i]);
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

// File: lcd_vectors.txt
# I rs value : expected init op, in table order
# W adr data nops rs0 data0 rs1 data1 : write and its expected panel ops
# R adr panel_value bus_data : read with the panel answer and expected bus data
# the first W line is issued while the init table is still playing
I 0 0001
I 0 0011
I 0 003A
I 1 0055
I 0 0036
I 1 0048
I 0 0013
I 0 0029
W 0 0000002C 1 0 002C 0 0000
R 3 0000 00000001
W 0 0001ABCD 1 1 ABCD 0 0000
W 1 F800001F 2 1 F800 1 001F
R 2 5A5A 00005A5A
W 1 07E0FFFF 2 1 07E0 1 FFFF
W 0 FFFE1234 1 0 1234 0 0000
W 3 12345678 0 0 0000 0 0000
R 0 BEEF 00000000
R 2 C3A5 0000C3A5
W 0 00010029 1 1 0029 0 0000
R 3 0000 00000001

// File: all.f
lcd_pkg.sv
lcd_bus_slave.sv
lcd_xfer_seq.sv
lcd_init_seq.sv
lcd_pin_timing.sv
lcd_top.sv
lcd_top_properties.sv
tb_lcd_top.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_lcd_top -f all.f
	./obj_dir/Vtb_lcd_top

clean:
	rm -rf obj_dir
